// ==== include/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
`define ICACHE_WAYS        4
`define ICACHE_SETS        256
`define ICACHE_LINE_WORDS  4

// address split, tag | index | byte offset
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     8
`define ICACHE_OFFSET_W    4

// data path
`define ICACHE_WORD_W      32

`endif

// ==== design/icache_ctrl_pkg.sv ====
`default_nettype none

package icache_ctrl_pkg;

    // controller FSM states
    typedef enum logic [2:0] {
        idle,
        lookup,
        replace,
        refill,
        retry
    } state_e;

    // cacop operations; mode 0 is not supported
    typedef enum logic [1:0] {
        index_inv = 2'd1,
        hit_inv   = 2'd2
    } cacop_op_e;

    // bus read size
    typedef enum logic [2:0] {
        rd_word = 3'b010,
        rd_line = 3'b100
    } rd_type_e;

endpackage

`default_nettype wire

// ==== design/icache_mem_pkg.sv ====
`default_nettype none

`include "icache_defines.svh"

package icache_mem_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]  index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;
    typedef logic [`ICACHE_TAG_W+`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0] addr_t;

    // data
    typedef logic [`ICACHE_WORD_W-1:0] word_t;
    // word 0 sits in the low bits
    typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_W-1:0] line_t;

    // bit n selects way n
    typedef logic [`ICACHE_WAYS-1:0] way_oh_t;

endpackage

`default_nettype wire

// ==== design/icache_way.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_way (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire icache_mem_pkg::index_t  req_index,
    input  wire icache_mem_pkg::tag_t    req_tag,
    input  wire                          fill_en,
    input  wire                          inval_en,
    input  wire icache_mem_pkg::line_t   fill_line,
    output logic                         way_valid,
    output logic                         way_hit,
    output icache_mem_pkg::line_t        way_line
);

    icache_mem_pkg::tag_t  tag_ram  [`ICACHE_SETS];
    icache_mem_pkg::line_t data_ram [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_bits;

    // tag and data are written together on refill
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_ram[req_index]  <= req_tag;
            data_ram[req_index] <= fill_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (fill_en) begin
            valid_bits[req_index] <= 1'b1;
        end else if (inval_en) begin
            // invalidate only drops the valid bit
            valid_bits[req_index] <= 1'b0;
        end
    end

    // asynchronous read at the buffered index
    assign way_valid = valid_bits[req_index];
    assign way_hit   = way_valid && tag_ram[req_index] == req_tag;
    assign way_line  = data_ram[req_index];

    // controller never refills and invalidates in the same cycle
    assert property (@(posedge clk) disable iff (!resetn)
        !(fill_en && inval_en));

endmodule

`default_nettype wire

// ==== design/icache_way_select.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_way_select (
    input  wire [`ICACHE_WAYS-1:0]       way_valid,
    input  wire [`ICACHE_WAYS-1:0]       way_hit,
    input  wire icache_mem_pkg::line_t   way_line [`ICACHE_WAYS],
    input  wire icache_mem_pkg::offset_t offset,
    output logic                         cache_hit,
    output icache_mem_pkg::way_oh_t      hit_way,
    output icache_mem_pkg::way_oh_t      victim_way,
    output icache_mem_pkg::word_t        hit_word
);

    icache_mem_pkg::line_t hit_line;

    assign cache_hit = |way_hit;
    assign hit_way   = way_hit;

    // hits are one-hot so an OR works as the mux
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_line = hit_line | way_line[w];
            end
        end
    end

    assign hit_word = hit_line[offset[`ICACHE_OFFSET_W-1:2]*`ICACHE_WORD_W +: `ICACHE_WORD_W];

    // lowest invalid way wins, way 0 when the set is full
    always_comb begin
        victim_way = icache_mem_pkg::way_oh_t'(1);
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim_way = icache_mem_pkg::way_oh_t'(1 << w);
            end
        end
    end

    // a tag lives in at most one way of a set
    assert final ($onehot0(way_hit));

endmodule

`default_nettype wire

// ==== design/icache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_ctrl (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              valid,
    input  wire                              uncache_en,
    input  wire                              cacop_en,
    input  wire icache_ctrl_pkg::cacop_op_e  cacop_mode,
    input  wire icache_mem_pkg::tag_t        tag,
    input  wire icache_mem_pkg::index_t      index,
    input  wire icache_mem_pkg::offset_t     offset,
    input  wire                              cache_hit,
    input  wire icache_mem_pkg::way_oh_t     hit_way,
    input  wire icache_mem_pkg::way_oh_t     victim_way,
    input  wire icache_mem_pkg::word_t       hit_word,
    input  wire                              rd_rdy,
    input  wire                              ret_valid,
    input  wire                              ret_last,
    input  wire icache_mem_pkg::word_t       ret_data,
    output icache_mem_pkg::index_t           req_index,
    output icache_mem_pkg::tag_t             req_tag,
    output icache_mem_pkg::offset_t          req_offset,
    output icache_mem_pkg::line_t            fill_line,
    output icache_mem_pkg::way_oh_t          fill_way,
    output icache_mem_pkg::way_oh_t          inval_way,
    output logic                             addr_ok,
    output logic                             data_ok,
    output logic                             cacop_data_ok,
    output logic                             busy,
    output logic                             rd_req,
    output icache_ctrl_pkg::rd_type_e        rd_type,
    output icache_mem_pkg::addr_t            rd_addr,
    output icache_mem_pkg::word_t            rdata
);

    icache_ctrl_pkg::state_e               state;
    icache_mem_pkg::tag_t                  buf_tag;
    icache_mem_pkg::index_t                buf_index;
    icache_mem_pkg::offset_t               buf_offset;
    icache_ctrl_pkg::cacop_op_e            buf_mode;
    logic                                  buf_uncache;
    logic                                  buf_cacop;
    logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_cnt;
    icache_mem_pkg::word_t                 line_buf [`ICACHE_LINE_WORDS];
    logic                                  take;
    logic                                  last_beat;

    assign take      = (valid || cacop_en) && state == icache_ctrl_pkg::idle;
    assign last_beat = state == icache_ctrl_pkg::refill && ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= icache_ctrl_pkg::idle;
            buf_uncache <= 1'b0;
            buf_cacop   <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            case (state)
                icache_ctrl_pkg::idle: begin
                    if (take) begin
                        state <= icache_ctrl_pkg::lookup;
                    end
                end
                icache_ctrl_pkg::lookup: begin
                    // cacop and cached hits finish here
                    if (buf_cacop || (cache_hit && !buf_uncache)) begin
                        state <= icache_ctrl_pkg::idle;
                    end else begin
                        state <= icache_ctrl_pkg::replace;
                    end
                end
                icache_ctrl_pkg::replace: begin
                    if (rd_rdy) begin
                        state <= icache_ctrl_pkg::refill;
                    end
                end
                icache_ctrl_pkg::refill: begin
                    if (ret_valid && ret_last) begin
                        if (buf_uncache) begin
                            state <= icache_ctrl_pkg::idle;
                        end else begin
                            state <= icache_ctrl_pkg::retry;
                        end
                    end
                end
                icache_ctrl_pkg::retry: begin
                    state <= icache_ctrl_pkg::idle;
                end
                default: begin
                    state <= icache_ctrl_pkg::idle;
                end
            endcase
            if (take) begin
                // cacop always goes through the arrays
                buf_uncache <= uncache_en && !cacop_en;
                buf_cacop   <= cacop_en;
            end
            if (state == icache_ctrl_pkg::replace) begin
                beat_cnt <= '0;
            end else if (state == icache_ctrl_pkg::refill && ret_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // request payload and line buffer
    always_ff @(posedge clk) begin
        if (take) begin
            buf_tag    <= tag;
            buf_index  <= index;
            buf_offset <= offset;
            buf_mode   <= cacop_mode;
        end
        if (state == icache_ctrl_pkg::refill && ret_valid) begin
            line_buf[beat_cnt] <= ret_data;
        end
    end

    // last beat bypasses the buffer so the line is whole at the fill edge
    always_comb begin
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            if (w == beat_cnt) begin
                fill_line[w*`ICACHE_WORD_W +: `ICACHE_WORD_W] = ret_data;
            end else begin
                fill_line[w*`ICACHE_WORD_W +: `ICACHE_WORD_W] = line_buf[w];
            end
        end
    end

    assign fill_way = (last_beat && !buf_uncache) ? victim_way : '0;

    always_comb begin
        inval_way = '0;
        if (state == icache_ctrl_pkg::lookup && buf_cacop) begin
            case (buf_mode)
                // way number comes from the low offset bits
                icache_ctrl_pkg::index_inv: inval_way[buf_offset[1:0]] = 1'b1;
                icache_ctrl_pkg::hit_inv: begin
                    if (cache_hit) begin
                        inval_way = hit_way;
                    end
                end
                default: inval_way = '0;
            endcase
        end
    end

    assign req_index     = buf_index;
    assign req_tag       = buf_tag;
    assign req_offset    = buf_offset;
    assign addr_ok       = state == icache_ctrl_pkg::lookup;
    assign cacop_data_ok = state == icache_ctrl_pkg::lookup && buf_cacop;
    assign busy          = state != icache_ctrl_pkg::idle;
    assign rd_req        = state == icache_ctrl_pkg::replace;
    assign rdata         = buf_uncache ? ret_data : hit_word;

    always_comb begin
        if (buf_uncache) begin
            data_ok = last_beat;
        end else begin
            data_ok = cache_hit && ((state == icache_ctrl_pkg::lookup && !buf_cacop) ||
                                    state == icache_ctrl_pkg::retry);
        end
    end

    // uncached reads fetch the exact word, refills the aligned line
    always_comb begin
        if (buf_uncache) begin
            rd_type = icache_ctrl_pkg::rd_word;
            rd_addr = {buf_tag, buf_index, buf_offset};
        end else begin
            rd_type = icache_ctrl_pkg::rd_line;
            rd_addr = {buf_tag, buf_index, icache_mem_pkg::offset_t'(0)};
        end
    end

    // the freshly refilled line has to hit in retry
    assert property (@(posedge clk) disable iff (!resetn)
        state == icache_ctrl_pkg::retry |-> cache_hit);

    assert property (@(posedge clk) disable iff (!resetn)
        cacop_en && !busy |-> cacop_mode != 2'd0);

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_top (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              valid,
    input  wire                              uncache_en,
    input  wire                              cacop_en,
    input  wire icache_ctrl_pkg::cacop_op_e  cacop_mode,
    input  wire icache_mem_pkg::tag_t        tag,
    input  wire icache_mem_pkg::index_t      index,
    input  wire icache_mem_pkg::offset_t     offset,
    output logic                             addr_ok,
    output logic                             data_ok,
    output logic                             cacop_data_ok,
    output icache_mem_pkg::word_t            rdata,
    output logic                             busy,
    output logic                             rd_req,
    output icache_ctrl_pkg::rd_type_e        rd_type,
    output icache_mem_pkg::addr_t            rd_addr,
    input  wire                              rd_rdy,
    input  wire                              ret_valid,
    input  wire                              ret_last,
    input  wire icache_mem_pkg::word_t       ret_data
);

    icache_mem_pkg::index_t  req_index;
    icache_mem_pkg::tag_t    req_tag;
    icache_mem_pkg::offset_t req_offset;
    icache_mem_pkg::line_t   fill_line;
    icache_mem_pkg::way_oh_t fill_way;
    icache_mem_pkg::way_oh_t inval_way;
    icache_mem_pkg::way_oh_t hit_way;
    icache_mem_pkg::way_oh_t victim_way;
    icache_mem_pkg::word_t   hit_word;
    logic                    cache_hit;
    logic [`ICACHE_WAYS-1:0] way_valid;
    logic [`ICACHE_WAYS-1:0] way_hit;
    icache_mem_pkg::line_t   way_line [`ICACHE_WAYS];

    icache_ctrl ctrl_i (
        .clk, .resetn, .valid, .uncache_en, .cacop_en, .cacop_mode,
        .tag, .index, .offset,
        .cache_hit, .hit_way, .victim_way, .hit_word,
        .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .req_index, .req_tag, .req_offset, .fill_line, .fill_way, .inval_way,
        .addr_ok, .data_ok, .cacop_data_ok, .busy,
        .rd_req, .rd_type, .rd_addr, .rdata
    );

    // all ways see the same index and tag, strobes are per way
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way way_i (
            .clk       (clk),
            .resetn    (resetn),
            .req_index (req_index),
            .req_tag   (req_tag),
            .fill_en   (fill_way[w]),
            .inval_en  (inval_way[w]),
            .fill_line (fill_line),
            .way_valid (way_valid[w]),
            .way_hit   (way_hit[w]),
            .way_line  (way_line[w])
        );
    end

    icache_way_select sel_i (
        .way_valid  (way_valid),
        .way_hit    (way_hit),
        .way_line   (way_line),
        .offset     (req_offset),
        .cache_hit  (cache_hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .hit_word   (hit_word)
    );

endmodule

`default_nettype wire

// ==== sim/icache_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_mem_model (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              rd_req,
    input  wire icache_ctrl_pkg::rd_type_e   rd_type,
    input  wire icache_mem_pkg::addr_t       rd_addr,
    output logic                             rd_rdy,
    output logic                             ret_valid,
    output logic                             ret_last,
    output icache_mem_pkg::word_t            ret_data
);

    // contents follow the word address
    function automatic icache_mem_pkg::word_t mem_word(input icache_mem_pkg::addr_t a);
        return (a & ~32'h3) ^ 32'hC0DE_0000;
    endfunction

    initial begin
        icache_mem_pkg::addr_t base;
        int                    beats;
        // fixed seed for the back-pressure pattern
        void'($urandom(6373));
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (resetn && rd_req) begin
                // random delay before the bus accepts
                repeat ($urandom_range(3)) @(posedge clk);
                base  = rd_addr;
                beats = (rd_type == icache_ctrl_pkg::rd_line) ? `ICACHE_LINE_WORDS : 1;
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                for (int i = 0; i < beats; i++) begin
                    // optional one cycle gap
                    if ($urandom_range(1) == 1) begin
                        ret_valid <= 1'b0;
                        ret_last  <= 1'b0;
                        @(posedge clk);
                    end
                    ret_valid <= 1'b1;
                    ret_data  <= mem_word(icache_mem_pkg::addr_t'(base + 4 * i));
                    ret_last  <= (i == beats - 1);
                    @(posedge clk);
                end
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_defines.svh"

module icache_tb;

    localparam int max_wait   = 100;
    localparam int max_access = 64;

    logic                       clk;
    logic                       resetn;
    logic                       valid;
    logic                       uncache_en;
    logic                       cacop_en;
    icache_ctrl_pkg::cacop_op_e cacop_mode;
    icache_mem_pkg::tag_t       tag;
    icache_mem_pkg::index_t     index;
    icache_mem_pkg::offset_t    offset;
    logic                       addr_ok;
    logic                       data_ok;
    logic                       cacop_data_ok;
    icache_mem_pkg::word_t      rdata;
    logic                       busy;
    logic                       rd_req;
    icache_ctrl_pkg::rd_type_e  rd_type;
    icache_mem_pkg::addr_t      rd_addr;
    logic                       rd_rdy;
    logic                       ret_valid;
    logic                       ret_last;
    icache_mem_pkg::word_t      ret_data;

    // four entries per access: op, address, miss flag, word
    logic [31:0] stim_mem [4*max_access];

    icache_top dut_i (
        .clk, .resetn, .valid, .uncache_en, .cacop_en, .cacop_mode,
        .tag, .index, .offset,
        .addr_ok, .data_ok, .cacop_data_ok, .rdata, .busy,
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data
    );

    icache_mem_model mem_i (
        .clk, .resetn, .rd_req, .rd_type, .rd_addr,
        .rd_rdy, .ret_valid, .ret_last, .ret_data
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_word(input string name, input icache_mem_pkg::word_t got,
                              input icache_mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_rd_type(input icache_ctrl_pkg::rd_type_e got,
                                 input icache_ctrl_pkg::rd_type_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t rd_type: got %s, expected %s", $time, got.name(), exp.name());
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string name, input icache_mem_pkg::addr_t got,
                              input icache_mem_pkg::addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        @(posedge clk);
        while (busy) begin
            n++;
            if (n > max_wait) begin
                $display("timeout: busy stayed high for %0d cycles", max_wait);
                stop_on_failure();
            end
            @(posedge clk);
        end
    endtask

    // bus request is checked once, when it first shows up
    task automatic note_bus_request(input icache_ctrl_pkg::rd_type_e exp_type,
                                    input icache_mem_pkg::addr_t exp_addr,
                                    inout logic saw_req);
        if (rd_req && !saw_req) begin
            check_rd_type(rd_type, exp_type);
            check_addr("rd_addr", rd_addr, exp_addr);
            saw_req = 1'b1;
        end
    endtask

    task automatic wait_data_ok(input icache_ctrl_pkg::rd_type_e exp_type,
                                input icache_mem_pkg::addr_t exp_addr,
                                output int cycles, output logic saw_req);
        cycles  = 0;
        saw_req = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            // lookup is the first cycle after the accepting edge
            check_flag("addr_ok", addr_ok, cycles == 1);
            check_flag("cacop_data_ok", cacop_data_ok, 1'b0);
            note_bus_request(exp_type, exp_addr, saw_req);
            if (cycles > max_wait) begin
                $display("timeout: data_ok did not arrive within %0d cycles", max_wait);
                stop_on_failure();
            end
        end while (!data_ok);
    endtask

    task automatic wait_cacop_ok(output int cycles, output logic saw_req);
        cycles  = 0;
        saw_req = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            check_flag("addr_ok", addr_ok, cycles == 1);
            if (rd_req) begin
                saw_req = 1'b1;
            end
            if (cycles > max_wait) begin
                $display("timeout: cacop_data_ok did not arrive within %0d cycles", max_wait);
                stop_on_failure();
            end
        end while (!cacop_data_ok);
    endtask

    // op 0 read, 1 uncached, 2 index_inv, 3 hit_inv
    task automatic run_access(input logic [31:0] op, input icache_mem_pkg::addr_t addr,
                              input logic exp_miss, input icache_mem_pkg::word_t exp_word);
        int                        cycles;
        logic                      saw_req;
        logic                      is_cacop;
        icache_ctrl_pkg::rd_type_e exp_type;
        icache_mem_pkg::addr_t     exp_addr;
        is_cacop = op >= 2;
        if (op == 1) begin
            exp_type = icache_ctrl_pkg::rd_word;
            exp_addr = addr;
        end else begin
            exp_type = icache_ctrl_pkg::rd_line;
            exp_addr = addr & ~icache_mem_pkg::addr_t'((1 << `ICACHE_OFFSET_W) - 1);
        end
        wait_not_busy();
        valid      <= !is_cacop;
        uncache_en <= op == 1;
        cacop_en   <= is_cacop;
        cacop_mode <= (op == 3) ? icache_ctrl_pkg::hit_inv : icache_ctrl_pkg::index_inv;
        tag        <= addr[`ICACHE_OFFSET_W+`ICACHE_INDEX_W +: `ICACHE_TAG_W];
        index      <= addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        offset     <= addr[`ICACHE_OFFSET_W-1:0];
        // accepting edge
        @(posedge clk);
        valid      <= 1'b0;
        uncache_en <= 1'b0;
        cacop_en   <= 1'b0;
        if (is_cacop) begin
            wait_cacop_ok(cycles, saw_req);
            check_flag("data_ok during cacop", data_ok, 1'b0);
        end else begin
            wait_data_ok(exp_type, exp_addr, cycles, saw_req);
            check_word("rdata", rdata, exp_word);
            if (!exp_miss) begin
                check_flag("data_ok one cycle after accept", cycles == 1, 1'b1);
            end
        end
        check_flag("rd_req seen", saw_req, exp_miss);
    endtask

    initial begin
        int n;
        resetn     = 1'b0;
        valid      = 1'b0;
        uncache_en = 1'b0;
        cacop_en   = 1'b0;
        cacop_mode = icache_ctrl_pkg::index_inv;
        tag        = '0;
        index      = '0;
        offset     = '0;
        for (int i = 0; i < 4 * max_access; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("sim/icache_stim.txt", stim_mem);
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("rd_req", rd_req, 1'b0);
        check_flag("data_ok", data_ok, 1'b0);
        check_flag("addr_ok", addr_ok, 1'b0);
        check_flag("cacop_data_ok", cacop_data_ok, 1'b0);
        n = 0;
        // all ones in the op column ends the list
        while (n < max_access && stim_mem[4*n] !== '1) begin
            run_access(stim_mem[4*n], stim_mem[4*n+1], stim_mem[4*n+2][0], stim_mem[4*n+3]);
            n++;
        end
        if (n == 0) begin
            $display("no accesses found in the stim file");
            stop_on_failure();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/icache_stim.txt ====
// columns: op address expected_miss expected_word
// op: 0 cached read, 1 uncached read, 2 index_inv, 3 hit_inv
0 00001000 1 C0DE1000
0 00001004 0 C0DE1004
0 00001008 0 C0DE1008
0 0000100C 0 C0DE100C
0 00001000 0 C0DE1000
1 00002014 1 C0DE2014
0 00002014 1 C0DE2014
2 00000000 0 00000000
0 00001000 1 C0DE1000
3 00002010 0 00000000
0 00002018 1 C0DE2018
3 00003010 0 00000000
0 0000201C 0 C0DE201C
0 00001004 0 C0DE1004
0 00010100 1 C0DF0100
0 00020100 1 C0DC0100
0 00030100 1 C0DD0100
0 00040100 1 C0DA0100
0 00050100 1 C0DB0100
0 00020108 0 C0DC0108
0 00030108 0 C0DD0108
0 0004010C 0 C0DA010C
0 00010104 1 C0DF0104

// ==== project.f ====
+incdir+include
design/icache_ctrl_pkg.sv
design/icache_mem_pkg.sv
design/icache_way.sv
design/icache_way_select.sv
design/icache_ctrl.sv
design/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/icache_ctrl_pkg.sv
      - design/icache_mem_pkg.sv
      - design/icache_way.sv
      - design/icache_way_select.sv
      - design/icache_ctrl.sv
      - design/icache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/icache_mem_model.sv
      - sim/icache_tb.sv
